/* build.f */
verilog/dcache_pkg.sv
verilog/dcache_d0.sv
verilog/dcache_d1.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
sim/dcache_tb.sv

/* sim/dcache_tb.sv */
// Memory model covers only the low 4 KiB of addresses and answers reads 1 to 4 cycles late
`timescale 1ns/100ps

module dcache_tb;

    localparam int          CLK_HALF    = 50;
    localparam int          DRIVE_DELAY = 1;
    localparam int          MEM_BYTES   = 4096;
    localparam int          TIMEOUT     = 200;
    localparam logic [31:0] RAND_SEED   = 32'h8299;

    logic                              clk = 1'b0;
    logic                              n_rst;
    logic                              i_req_valid;
    dcache_pkg::dc_req_t               i_req;
    logic                              o_ready;
    logic                              o_resp_valid;
    dcache_pkg::dc_resp_t              o_resp;
    logic                              o_mem_req_valid;
    dcache_pkg::dc_mem_req_t           o_mem_req;
    logic                              i_mem_resp_valid;
    logic [dcache_pkg::LINE_WIDTH-1:0] i_mem_resp_data;

    // mem is the backing store and shadow is what the core should observe
    logic [7:0]              mem    [MEM_BYTES];
    logic [7:0]              shadow [MEM_BYTES];
    int                      cyc = 0;
    dcache_pkg::dc_resp_t    exp_q[$];
    int                      issue_q[$];
    dcache_pkg::dc_resp_t    got_q[$];
    int                      got_cyc_q[$];
    dcache_pkg::dc_mem_req_t memq[$];

    dcache u_dut (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .o_ready          (o_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp           (o_resp),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_resp_valid (i_mem_resp_valid),
        .i_mem_resp_data  (i_mem_resp_data)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [7:0] fill_byte(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9E37_79B1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic int slot(input logic [31:0] addr);
        return int'(addr % MEM_BYTES);
    endfunction

    function automatic logic [dcache_pkg::LINE_WIDTH-1:0] mem_line(input logic [31:0] base);
        logic [dcache_pkg::LINE_WIDTH-1:0] l;
        for (int b = 0; b < dcache_pkg::LINE_SIZE; b++) begin
            l[b*8 +: 8] = mem[slot(base + b)];
        end
        return l;
    endfunction

    function automatic logic [dcache_pkg::LINE_WIDTH-1:0] shadow_line(input logic [31:0] base);
        logic [dcache_pkg::LINE_WIDTH-1:0] l;
        for (int b = 0; b < dcache_pkg::LINE_SIZE; b++) begin
            l[b*8 +: 8] = shadow[slot(base + b)];
        end
        return l;
    endfunction

    function automatic dcache_pkg::dc_req_t make_req(input dcache_pkg::dc_op_t op,
            input logic [31:0] addr, input logic [3:0] sel, input logic [31:0] data);
        dcache_pkg::dc_req_t r;
        r.op       = op;
        r.tag      = addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
        r.index    = addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
        r.offset   = addr[dcache_pkg::OFFSET_WIDTH-1:0];
        r.byte_sel = sel;
        r.data     = data;
        return r;
    endfunction

    function automatic dcache_pkg::dc_mem_req_t mem_req(input logic write,
            input logic [31:0] addr, input logic [dcache_pkg::LINE_WIDTH-1:0] data);
        dcache_pkg::dc_mem_req_t m;
        m.write = write;
        m.addr  = addr;
        m.data  = data;
        return m;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: %s expected %b actual %b", name, what, exp, act));
        end
    endtask

    task automatic check_int(input string name, input string what, input int exp,
                             input int act);
        if (act != exp) begin
            stop_run($sformatf("FAIL %s: %s expected %0d actual %0d", name, what, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input dcache_pkg::dc_resp_t exp,
                              input dcache_pkg::dc_resp_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: response expected op %0d data %h actual op %0d data %h",
                               name, exp.op, exp.data, act.op, act.data));
        end
    endtask

    // Read requests carry no meaningful line data
    task automatic check_mem_req(input string name, input dcache_pkg::dc_mem_req_t exp,
                                 input dcache_pkg::dc_mem_req_t act);
        if (act.write !== exp.write || act.addr !== exp.addr ||
            (exp.write && act.data !== exp.data)) begin
            stop_run($sformatf("FAIL %s: mem request expected %b %h %h actual %b %h %h", name,
                               exp.write, exp.addr, exp.data, act.write, act.addr, act.data));
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Expected data follows program order, so stores update the shadow as they are issued
    task automatic strobe(input dcache_pkg::dc_req_t req);
        dcache_pkg::dc_resp_t exp;
        logic [31:0]          base;
        int                   pos;
        int                   waited;
        waited = 0;
        while (o_ready !== 1'b1) begin
            if (waited == TIMEOUT) begin
                stop_run("Timeout: the cache never raised o_ready for the next request");
            end
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        base     = {req.tag, req.index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
        exp.op   = req.op;
        exp.data = '0;
        for (int j = 0; j < dcache_pkg::WORD_SIZE; j++) begin
            pos = int'(req.offset) + j;
            if (req.byte_sel[j] && pos < dcache_pkg::LINE_SIZE) begin
                if (req.op == dcache_pkg::DC_STORE) begin
                    shadow[slot(base + pos)] = req.data[j*8 +: 8];
                end else begin
                    exp.data[j*8 +: 8] = shadow[slot(base + pos)];
                end
            end
        end
        exp_q.push_back(exp);
        issue_q.push_back(cyc);
        i_req_valid = 1'b1;
        i_req       = req;
        @(posedge clk);
        #DRIVE_DELAY;
        i_req_valid = 1'b0;
    endtask

    task automatic collect(input string name, input bit check_lat);
        int waited;
        int latency;
        waited = 0;
        while (got_q.size() < exp_q.size()) begin
            if (waited == TIMEOUT) begin
                stop_run({"Timeout in ", name, ": a response never arrived"});
            end
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        while (exp_q.size() > 0) begin
            latency = got_cyc_q.pop_front() - issue_q.pop_front();
            check_resp(name, exp_q.pop_front(), got_q.pop_front());
            if (check_lat) begin
                check_int(name, "hit latency", 2, latency);
            end
        end
        idle(4);
        check_int(name, "extra responses", 0, got_q.size());
    endtask

    task automatic after_reset();
        idle(2);
        check_flag("reset_state", "o_ready", 1'b1, o_ready);
        check_flag("reset_state", "o_resp_valid", 1'b0, o_resp_valid);
        check_flag("reset_state", "o_mem_req_valid", 1'b0, o_mem_req_valid);
    endtask

    task automatic read_miss();
        memq.delete();
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h45, 4'hF, '0));
        collect("read_miss", 1'b0);
        check_int("read_miss", "memory requests", 1, memq.size());
        check_mem_req("read_miss", mem_req(1'b0, 32'h40, '0), memq[0]);
    endtask

    // Each load right behind a store to its line reads through the bypass
    task automatic store_hit_pipeline();
        memq.delete();
        strobe(make_req(dcache_pkg::DC_STORE, 32'h44, 4'b0110, 32'h1234_5678));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h44, 4'hF, '0));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h58, 4'hF, '0));
        strobe(make_req(dcache_pkg::DC_STORE, 32'h5C, 4'hF, 32'hCAFE_F00D));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h5C, 4'b1001, '0));
        collect("store_hit", 1'b1);
        check_int("store_hit", "memory requests", 0, memq.size());
    endtask

    task automatic dirty_eviction();
        logic [dcache_pkg::LINE_WIDTH-1:0] old_line;
        memq.delete();
        old_line = shadow_line(32'h40);
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h448, 4'hF, '0));
        collect("dirty_evict", 1'b0);
        // Reloading the old line proves the written-back bytes reached memory
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h44, 4'hF, '0));
        collect("dirty_evict", 1'b0);
        check_int("dirty_evict", "memory requests", 3, memq.size());
        check_mem_req("dirty_evict", mem_req(1'b1, 32'h40, old_line), memq[0]);
        check_mem_req("dirty_evict", mem_req(1'b0, 32'h440, '0), memq[1]);
        check_mem_req("dirty_evict", mem_req(1'b0, 32'h40, '0), memq[2]);
    endtask

    task automatic line_end();
        memq.delete();
        strobe(make_req(dcache_pkg::DC_STORE, 32'h7E, 4'hF, 32'hA1B2_C3D4));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h7E, 4'hF, '0));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h80, 4'hF, '0));
        collect("line_end", 1'b0);
        check_int("line_end", "memory requests", 2, memq.size());
        check_mem_req("line_end", mem_req(1'b0, 32'h60, '0), memq[0]);
        check_mem_req("line_end", mem_req(1'b0, 32'h80, '0), memq[1]);
    endtask

    task automatic miss_then_hit();
        memq.delete();
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h104, 4'hF, '0));
        strobe(make_req(dcache_pkg::DC_LOAD, 32'h48, 4'b0011, '0));
        collect("miss_then_hit", 1'b0);
        check_int("miss_then_hit", "memory requests", 1, memq.size());
        check_mem_req("miss_then_hit", mem_req(1'b0, 32'h100, '0), memq[0]);
    endtask

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (n_rst === 1'b1 && o_resp_valid === 1'b1) begin
            got_q.push_back(o_resp);
            got_cyc_q.push_back(cyc);
        end
    end

    // Memory model with one outstanding read and a random response delay
    initial begin
        bit          rd_pending;
        int unsigned rd_delay;
        logic [31:0] rd_addr;
        i_mem_resp_valid = 1'b0;
        i_mem_resp_data  = '0;
        rd_pending       = 1'b0;
        rd_delay         = 0;
        rd_addr          = '0;
        void'($urandom(RAND_SEED));
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            i_mem_resp_valid = 1'b0;
            if (rd_pending) begin
                if (rd_delay == 0) begin
                    i_mem_resp_valid = 1'b1;
                    i_mem_resp_data  = mem_line(rd_addr);
                    rd_pending       = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            if (n_rst === 1'b1 && o_mem_req_valid === 1'b1) begin
                memq.push_back(o_mem_req);
                if (o_mem_req.write) begin
                    for (int b = 0; b < dcache_pkg::LINE_SIZE; b++) begin
                        mem[slot(o_mem_req.addr + b)] = o_mem_req.data[b*8 +: 8];
                    end
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = o_mem_req.addr;
                    rd_delay   = $urandom % 4;
                end
            end
        end
    end

    initial begin
        n_rst       = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a]    = fill_byte(a);
            shadow[a] = fill_byte(a);
        end
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        n_rst = 1'b1;
        after_reset();
        read_miss();
        store_hit_pipeline();
        dirty_eviction();
        line_end();
        miss_then_hit();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog/dcache.sv */
// Requests are strobed only while o_ready is high and hits answer two cycles later
`timescale 1ns/100ps

module dcache (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 i_req_valid,
    input  dcache_pkg::dc_req_t                  i_req,
    output logic                                 o_ready,
    output logic                                 o_resp_valid,
    output dcache_pkg::dc_resp_t                 o_resp,
    output logic                                 o_mem_req_valid,
    output dcache_pkg::dc_mem_req_t              o_mem_req,
    input  logic                                 i_mem_resp_valid,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]    i_mem_resp_data
);

    logic                                  d0_in_valid;
    dcache_pkg::dc_pipe_t                  d0_in_item;
    logic                                  kill;
    logic [dcache_pkg::INDEX_WIDTH-1:0]    rd_index;
    logic                                  d0_valid;
    dcache_pkg::dc_pipe_t                  d0_item;
    dcache_pkg::dc_line_rd_t               rd_line;
    logic                                  wr_en;
    dcache_pkg::dc_line_wr_t               wr_line;
    logic                                  d1_resp_valid;
    logic                                  d1_hit;
    dcache_pkg::dc_op_t                    d1_op;
    logic [dcache_pkg::DATA_WIDTH-1:0]     d1_data;
    dcache_pkg::dc_victim_t                victim;
    logic                                  resp_suppress;

    assign o_resp_valid = d1_resp_valid & ~resp_suppress;
    assign o_resp.op    = d1_op;
    assign o_resp.data  = d1_data;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .i_d0_valid       (d0_valid),
        .i_d1_valid       (d1_resp_valid),
        .i_d1_hit         (d1_hit),
        .i_victim         (victim),
        .i_mem_resp_valid (i_mem_resp_valid),
        .i_mem_resp_data  (i_mem_resp_data),
        .o_ready          (o_ready),
        .o_d0_valid       (d0_in_valid),
        .o_d0_item        (d0_in_item),
        .o_kill           (kill),
        .o_resp_suppress  (resp_suppress),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_req        (o_mem_req)
    );

    dcache_d0 u_d0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_valid    (d0_in_valid),
        .i_item     (d0_in_item),
        .i_kill     (kill),
        .o_rd_index (rd_index),
        .o_valid    (d0_valid),
        .o_item     (d0_item)
    );

    dcache_array u_array (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_index (rd_index),
        .o_rd       (rd_line),
        .i_wr_en    (wr_en),
        .i_wr       (wr_line)
    );

    dcache_d1 u_d1 (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_valid      (d0_valid),
        .i_item       (d0_item),
        .i_rd         (rd_line),
        .o_wr_en      (wr_en),
        .o_wr         (wr_line),
        .o_resp_valid (d1_resp_valid),
        .o_hit        (d1_hit),
        .o_op         (d1_op),
        .o_data       (d1_data),
        .o_victim     (victim)
    );

endmodule

/* verilog/dcache_ctrl.sv */
// One memory request at a time; a write is followed by two idle cycles before the fetch
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 i_req_valid,
    input  dcache_pkg::dc_req_t                  i_req,
    input  logic                                 i_d0_valid,
    input  logic                                 i_d1_valid,
    input  logic                                 i_d1_hit,
    input  dcache_pkg::dc_victim_t               i_victim,
    input  logic                                 i_mem_resp_valid,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]    i_mem_resp_data,
    output logic                                 o_ready,
    output logic                                 o_d0_valid,
    output dcache_pkg::dc_pipe_t                 o_d0_item,
    output logic                                 o_kill,
    output logic                                 o_resp_suppress,
    output logic                                 o_mem_req_valid,
    output dcache_pkg::dc_mem_req_t              o_mem_req
);

    typedef enum logic [2:0] {
        IDLE, WRITEBACK, FETCH, FILL, REPLAY
    } state_t;

    state_t                            state;
    logic                              miss;
    logic [1:0]                        wb_cnt;
    logic                              rd_sent;
    logic                              rp_sel;
    logic                              buf1_valid;
    dcache_pkg::dc_req_t               p0_req;
    dcache_pkg::dc_req_t               p1_req;
    dcache_pkg::dc_req_t               buf0;
    dcache_pkg::dc_req_t               buf1;
    dcache_pkg::dc_victim_t            victim_q;
    logic [dcache_pkg::LINE_WIDTH-1:0] fill_q;

    // p1_req is the request whose result d1 is presenting now
    assign miss            = (state == IDLE) & i_d1_valid & ~i_d1_hit;
    assign o_ready         = (state == IDLE) & ~miss;
    assign o_kill          = miss;
    assign o_resp_suppress = (state != IDLE) | ~i_d1_hit;

    always_comb begin
        o_d0_item.req       = i_req;
        o_d0_item.fill      = 1'b0;
        o_d0_item.fill_data = fill_q;
        o_d0_item.valid     = 1'b1;
        o_d0_item.dirty     = 1'b1;
        o_d0_valid          = 1'b0;
        case (state)
            IDLE: o_d0_valid = i_req_valid;
            FILL: begin
                o_d0_item.req   = buf0;
                o_d0_item.fill  = 1'b1;
                o_d0_item.dirty = 1'b0;
                o_d0_valid      = 1'b1;
            end
            REPLAY: begin
                o_d0_item.req = rp_sel ? buf1 : buf0;
                o_d0_valid    = 1'b1;
            end
            default: o_d0_valid = 1'b0;
        endcase
    end

    always_comb begin
        o_mem_req.write = 1'b0;
        o_mem_req.addr  = {buf0.tag, buf0.index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
        o_mem_req.data  = victim_q.data;
        o_mem_req_valid = 1'b0;
        if (state == WRITEBACK) begin
            o_mem_req.write = 1'b1;
            o_mem_req.addr  = victim_q.addr;
            o_mem_req_valid = (wb_cnt == 2'd0);
        end else if (state == FETCH) begin
            o_mem_req_valid = ~rd_sent;
        end
    end

    always_ff @(posedge clk) begin
        p0_req <= o_d0_item.req;
        p1_req <= p0_req;
        if (miss) begin
            buf0     <= p1_req;
            buf1     <= p0_req;
            victim_q <= i_victim;
        end
        if (i_mem_resp_valid) begin
            fill_q <= i_mem_resp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state      <= IDLE;
            wb_cnt     <= 2'd0;
            rd_sent    <= 1'b0;
            rp_sel     <= 1'b0;
            buf1_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        // The younger request in d0 is replayed, so its d1 result is dropped
                        buf1_valid <= i_d0_valid;
                        wb_cnt     <= 2'd0;
                        rd_sent    <= 1'b0;
                        state      <= (i_victim.valid & i_victim.dirty) ? WRITEBACK : FETCH;
                    end
                end
                WRITEBACK: begin
                    wb_cnt <= wb_cnt + 2'd1;
                    if (wb_cnt == 2'd2) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    rd_sent <= 1'b1;
                    if (i_mem_resp_valid) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    rp_sel <= 1'b0;
                    state  <= REPLAY;
                end
                REPLAY: begin
                    rp_sel <= 1'b1;
                    if (rp_sel || !buf1_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!n_rst)
        !o_ready |-> !i_req_valid
    );

    a_mem_resp_in_fetch: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_mem_resp_valid |-> (state == FETCH) && rd_sent
    );

endmodule

/* verilog/dcache_array.sv */
// A read and a write to the same index on one edge return the old contents
`timescale 1ns/100ps

module dcache_array (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]   i_rd_index,
    output dcache_pkg::dc_line_rd_t              o_rd,
    input  logic                                 i_wr_en,
    input  dcache_pkg::dc_line_wr_t              i_wr
);

    logic [dcache_pkg::LINE_WIDTH-1:0] line_mem [dcache_pkg::LINE_COUNT];
    logic [dcache_pkg::TAG_WIDTH-1:0]  tag_mem  [dcache_pkg::LINE_COUNT];
    logic [dcache_pkg::LINE_COUNT-1:0] valid_vec;
    logic [dcache_pkg::LINE_COUNT-1:0] dirty_vec;

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_mem[i_wr.index] <= i_wr.data;
            tag_mem[i_wr.index]  <= i_wr.tag;
        end
    end

    // The cache starts empty with every valid and dirty bit clear
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_vec <= '0;
            dirty_vec <= '0;
        end else if (i_wr_en) begin
            valid_vec[i_wr.index] <= i_wr.valid;
            dirty_vec[i_wr.index] <= i_wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        o_rd.tag   <= tag_mem[i_rd_index];
        o_rd.data  <= line_mem[i_rd_index];
        o_rd.valid <= valid_vec[i_rd_index];
        o_rd.dirty <= dirty_vec[i_rd_index];
    end

endmodule

/* verilog/dcache_d1.sv */
// Bytes past the end of the line read as zero and are never written
`timescale 1ns/100ps

module dcache_d1 (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 i_valid,
    input  dcache_pkg::dc_pipe_t                 i_item,
    input  dcache_pkg::dc_line_rd_t              i_rd,
    output logic                                 o_wr_en,
    output dcache_pkg::dc_line_wr_t              o_wr,
    output logic                                 o_resp_valid,
    output logic                                 o_hit,
    output dcache_pkg::dc_op_t                   o_op,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    o_data,
    output dcache_pkg::dc_victim_t               o_victim
);

    logic                                 wr_seen;
    logic                                 bypass;
    logic                                 bypass_hit;
    logic [dcache_pkg::TAG_WIDTH-1:0]     cur_tag;
    logic                                 cur_valid;
    logic                                 cur_dirty;
    logic [dcache_pkg::LINE_WIDTH-1:0]    cur_line;
    logic [dcache_pkg::LINE_WIDTH-1:0]    victim_line;
    logic                                 cache_hit;
    logic                                 wr_now;
    logic [dcache_pkg::DATA_WIDTH-1:0]    rd_data;
    logic [dcache_pkg::LINE_WIDTH-1:0]    wr_data;

    // o_wr only changes on a write, so it always holds the newest contents of its index.
    // The array may still be absorbing it, or may have read the old line on that same edge
    assign bypass     = wr_seen & (o_wr.index == i_item.req.index);
    assign bypass_hit = bypass & (o_wr.tag == i_item.req.tag);

    assign cur_tag     = bypass ? o_wr.tag : i_rd.tag;
    assign cur_valid   = bypass ? o_wr.valid : i_rd.valid;
    assign cur_dirty   = bypass ? o_wr.dirty : i_rd.dirty;
    assign cur_line    = bypass_hit ? o_wr.data : i_rd.data;
    assign victim_line = bypass ? o_wr.data : i_rd.data;

    // A fill installs its own tag, so it counts as a hit
    assign cache_hit = i_item.fill | (cur_valid & (cur_tag == i_item.req.tag));

    assign wr_now = i_valid &
                    (i_item.fill | (cache_hit & (i_item.req.op == dcache_pkg::DC_STORE)));

    // Load bytes, clipped at the end of the line
    always_comb begin
        int pos;
        rd_data = '0;
        for (int j = 0; j < dcache_pkg::WORD_SIZE; j++) begin
            pos = int'(i_item.req.offset) + j;
            if (i_item.req.byte_sel[j] && (pos < dcache_pkg::LINE_SIZE)) begin
                rd_data[j*8 +: 8] = cur_line[pos*8 +: 8];
            end
        end
    end

    // Store merge uses the same clipping as the load path
    always_comb begin
        int pos;
        wr_data = cur_line;
        for (int j = 0; j < dcache_pkg::WORD_SIZE; j++) begin
            pos = int'(i_item.req.offset) + j;
            if (i_item.req.byte_sel[j] && (pos < dcache_pkg::LINE_SIZE)) begin
                wr_data[pos*8 +: 8] = i_item.req.data[j*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_wr_en      <= 1'b0;
            wr_seen      <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            o_wr_en      <= wr_now;
            wr_seen      <= wr_seen | wr_now;
            o_resp_valid <= i_valid & ~i_item.fill;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_now) begin
            o_wr.index <= i_item.req.index;
            o_wr.tag   <= i_item.req.tag;
            o_wr.data  <= i_item.fill ? i_item.fill_data : wr_data;
            o_wr.valid <= i_item.valid;
            o_wr.dirty <= i_item.dirty;
        end
    end

    always_ff @(posedge clk) begin
        o_hit          <= cache_hit;
        o_op           <= i_item.req.op;
        o_data         <= (i_item.req.op == dcache_pkg::DC_STORE) ? '0 : rd_data;
        o_victim.valid <= cur_valid;
        o_victim.dirty <= cur_dirty;
        o_victim.addr  <= {cur_tag, i_item.req.index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
        o_victim.data  <= victim_line;
    end

    // Every fill leaves a valid and clean line in the write register
    a_fill_writes: assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_valid && i_item.fill) |=> (o_wr.valid && !o_wr.dirty)
    );

endmodule

/* verilog/dcache_d0.sv */
// The array index is taken from the incoming item so the registered read lines up with o_item
`timescale 1ns/100ps

module dcache_d0 (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 i_valid,
    input  dcache_pkg::dc_pipe_t                 i_item,
    input  logic                                 i_kill,
    output logic [dcache_pkg::INDEX_WIDTH-1:0]   o_rd_index,
    output logic                                 o_valid,
    output dcache_pkg::dc_pipe_t                 o_item
);

    // The array registers its read on the same edge that captures the item
    assign o_rd_index = i_item.req.index;

    // A killed entry never reaches d1 as a live request
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_kill;
        end
    end

    always_ff @(posedge clk) begin
        o_item <= i_item;
    end

    // A fill is only injected once the pipeline has drained, so it never meets a core request
    a_fill_alone: assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_valid && i_item.fill) |-> !o_valid
    );

endmodule

/* verilog/dcache_pkg.sv */
// Geometry is fixed at 1 KiB direct mapped with 32-byte lines and a single way
package dcache_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int WORD_SIZE    = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH   = 32;
    localparam int LINE_SIZE    = 32;
    localparam int LINE_WIDTH   = LINE_SIZE * 8;
    localparam int CACHE_SIZE   = 1024;
    localparam int LINE_COUNT   = CACHE_SIZE / LINE_SIZE;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int INDEX_WIDTH  = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [0:0] {
        DC_LOAD  = 1'b0,
        DC_STORE = 1'b1
    } dc_op_t;

    typedef struct packed {
        dc_op_t                  op;
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [WORD_SIZE-1:0]    byte_sel;
        logic [DATA_WIDTH-1:0]   data;
    } dc_req_t;

    // Stores come back with zero data
    typedef struct packed {
        dc_op_t                op;
        logic [DATA_WIDTH-1:0] data;
    } dc_resp_t;

    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
        logic [LINE_WIDTH-1:0]  data;
        logic                   valid;
        logic                   dirty;
    } dc_line_wr_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [LINE_WIDTH-1:0] data;
        logic                  valid;
        logic                  dirty;
    } dc_line_rd_t;

    // Valid and dirty are the values written to the array if this item writes
    typedef struct packed {
        dc_req_t               req;
        logic                  fill;
        logic [LINE_WIDTH-1:0] fill_data;
        logic                  valid;
        logic                  dirty;
    } dc_pipe_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] data;
    } dc_victim_t;

    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] data;
    } dc_mem_req_t;

endpackage
